// ==== hdl/dbg_trig_consts.svh ====
// Debug trigger constants

`ifndef DBG_TRIG_CONSTS_SVH
`define DBG_TRIG_CONSTS_SVH

//////////////////////////////////////////////////////////////////////
// Trigger count
//////////////////////////////////////////////////////////////////////

`define DBG_TRIG_NUM 2  // Default number of triggers, at least 1

//////////////////////////////////////////////////////////////////////
// tdata1 field positions
//////////////////////////////////////////////////////////////////////

`define TDATA1_TTYPE_HIGH 31  // Trigger type field
`define TDATA1_TTYPE_LOW  28

`define MCONTROL6_MATCH_HIGH 10  // Compare mode field
`define MCONTROL6_MATCH_LOW  7

`define MCONTROL6_M       6  // Machine mode enable
`define MCONTROL6_U       3  // User mode enable, tied low
`define MCONTROL6_EXECUTE 2  // Instruction fetch enable
`define MCONTROL6_STORE   1  // Store enable
`define MCONTROL6_LOAD    0  // Load enable

//////////////////////////////////////////////////////////////////////
// Encodings
//////////////////////////////////////////////////////////////////////

`define TTYPE_MCONTROL6 4'h6  // Address match trigger
`define TTYPE_DISABLED  4'hF  // Trigger switched off

`define MATCH_EQ 4'h0  // Equal
`define MATCH_GE 4'h2  // Greater or equal, unsigned
`define MATCH_LT 4'h3  // Less than, unsigned

`define PRIV_LVL_M 2'd3  // Machine mode
`define PRIV_LVL_U 2'd0  // User mode

// Disabled type with dmode set
`define TDATA1_RST_VAL 32'hF800_0000

`endif

// ==== hdl/dbg_trig_pkg.sv ====
// Debug trigger types

`default_nettype none

package dbg_trig_pkg;

  // Register or address word
  typedef logic [31:0] xlen_t;

  // Privilege level, 3 is machine and 0 is user
  typedef logic [1:0] priv_lvl_t;

  // LSU byte enables, one per byte lane
  typedef logic [3:0] byte_en_t;

  // tdata1 type field
  typedef logic [3:0] ttype_t;

  // mcontrol6 match field
  typedef logic [3:0] match_mode_t;

endpackage

`default_nettype wire

// ==== hdl/trig_csr_file.sv ====
// Trigger CSR file

`timescale 1ns/1ps
`default_nettype none

`include "dbg_trig_consts.svh"

module trig_csr_file #(
  parameter int NUM_TRIGGERS = `DBG_TRIG_NUM
) (
  input  wire                 clk,
  input  wire                 rst_i,

  // CSR write port
  input  wire dbg_trig_pkg::xlen_t csr_wdata_i,
  input  wire                 tselect_we_i,
  input  wire                 tdata1_we_i,
  input  wire                 tdata2_we_i,

  // CSR read data
  output dbg_trig_pkg::xlen_t tselect_rdata_o,
  output dbg_trig_pkg::xlen_t tdata1_rdata_o,
  output dbg_trig_pkg::xlen_t tdata2_rdata_o,

  // Per trigger registers to the matchers
  output dbg_trig_pkg::xlen_t tdata1_all_o [NUM_TRIGGERS],
  output dbg_trig_pkg::xlen_t tdata2_all_o [NUM_TRIGGERS]
);

  // WARL resolution of the match field, only 0, 2 and 3 are kept
  function automatic dbg_trig_pkg::match_mode_t match_resolve(
    input dbg_trig_pkg::match_mode_t mode
  );
    case (mode)
      `MATCH_EQ, `MATCH_GE, `MATCH_LT: match_resolve = mode;
      default:                         match_resolve = `MATCH_EQ;
    endcase
  endfunction

  dbg_trig_pkg::xlen_t       tselect_q;             // Selected trigger index
  dbg_trig_pkg::xlen_t       tselect_n;
  dbg_trig_pkg::xlen_t       tdata1_n;              // Resolved tdata1 write value
  dbg_trig_pkg::xlen_t       tdata1_q [NUM_TRIGGERS];
  dbg_trig_pkg::xlen_t       tdata2_q [NUM_TRIGGERS];
  dbg_trig_pkg::ttype_t      wr_ttype;              // Type field of write data
  dbg_trig_pkg::match_mode_t wr_match;              // Resolved match field
  logic [NUM_TRIGGERS-1:0]   tdata1_we_int;         // Decoded per trigger strobes
  logic [NUM_TRIGGERS-1:0]   tdata2_we_int;

  //////////////////////////////////////////////////////////////////////
  // Write data resolution
  //////////////////////////////////////////////////////////////////////

  assign wr_ttype = csr_wdata_i[`TDATA1_TTYPE_HIGH:`TDATA1_TTYPE_LOW];
  assign wr_match = match_resolve(csr_wdata_i[`MCONTROL6_MATCH_HIGH:`MCONTROL6_MATCH_LOW]);

  // tselect ignores out of range indices
  always_comb begin
    if (csr_wdata_i < dbg_trig_pkg::xlen_t'(NUM_TRIGGERS)) begin
      tselect_n = csr_wdata_i;
    end else begin
      tselect_n = tselect_q;  // Keep current selection
    end
  end

  always_comb begin
    tdata1_n = tdata1_rdata_o;  // Unknown type keeps the old word
    if (wr_ttype == `TTYPE_MCONTROL6) begin
      tdata1_n = {
        `TTYPE_MCONTROL6,               // type 31:28
        1'b1,                           // dmode 27
        11'd0,                          // hit, select, timing, size 26:16
        4'h1,                           // action, enter debug 15:12
        1'b0,                           // chain 11
        wr_match,                       // match 10:7
        csr_wdata_i[`MCONTROL6_M],      // M 6
        3'b000,                         // S and U tied low 5:3
        csr_wdata_i[`MCONTROL6_EXECUTE],
        csr_wdata_i[`MCONTROL6_STORE],
        csr_wdata_i[`MCONTROL6_LOAD]
      };
    end else if (wr_ttype == `TTYPE_DISABLED) begin
      tdata1_n = `TDATA1_RST_VAL;     // Disabled with dmode
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Registers
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst_i) begin
      tselect_q <= '0;
    end else if (tselect_we_i) begin
      tselect_q <= tselect_n;
    end
  end

  for (genvar idx = 0; idx < NUM_TRIGGERS; idx++) begin : gen_trig_regs
    // Only the selected trigger sees the strobe
    assign tdata1_we_int[idx] = tdata1_we_i && (tselect_q == dbg_trig_pkg::xlen_t'(idx));
    assign tdata2_we_int[idx] = tdata2_we_i && (tselect_q == dbg_trig_pkg::xlen_t'(idx));

    always_ff @(posedge clk) begin
      if (rst_i) begin
        tdata1_q[idx] <= `TDATA1_RST_VAL;
      end else if (tdata1_we_int[idx]) begin
        tdata1_q[idx] <= tdata1_n;
      end
    end

    // Any value is legal in tdata2
    always_ff @(posedge clk) begin
      if (rst_i) begin
        tdata2_q[idx] <= '0;
      end else if (tdata2_we_int[idx]) begin
        tdata2_q[idx] <= csr_wdata_i;
      end
    end

    assign tdata1_all_o[idx] = tdata1_q[idx];
    assign tdata2_all_o[idx] = tdata2_q[idx];
  end

  //////////////////////////////////////////////////////////////////////
  // Read mux
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    tdata1_rdata_o = tdata1_q[0];  // Fallback to trigger 0
    tdata2_rdata_o = tdata2_q[0];
    for (int i = 0; i < NUM_TRIGGERS; i++) begin
      if (tselect_q == dbg_trig_pkg::xlen_t'(i)) begin
        tdata1_rdata_o = tdata1_q[i];
        tdata2_rdata_o = tdata2_q[i];
      end
    end
  end

  assign tselect_rdata_o = tselect_q;

endmodule

`default_nettype wire

// ==== hdl/trig_addr_match.sv ====
// Trigger address matcher

`timescale 1ns/1ps
`default_nettype none

`include "dbg_trig_consts.svh"

module trig_addr_match (
  // Trigger registers
  input  wire dbg_trig_pkg::xlen_t     tdata1_i,
  input  wire dbg_trig_pkg::xlen_t     tdata2_i,

  // IF stage
  input  wire dbg_trig_pkg::xlen_t     pc_if_i,
  input  wire dbg_trig_pkg::priv_lvl_t priv_lvl_if_i,

  // EX stage LSU request
  input  wire                          lsu_valid_ex_i,
  input  wire dbg_trig_pkg::xlen_t     lsu_addr_ex_i,
  input  wire                          lsu_we_ex_i,
  input  wire dbg_trig_pkg::byte_en_t  lsu_be_ex_i,
  input  wire dbg_trig_pkg::priv_lvl_t priv_lvl_ex_i,

  input  wire                          debug_mode_i,  // Core halted in debug mode

  output logic                         match_if_o,    // Instruction address hit
  output logic                         match_ex_o     // Load/store address hit
);

  dbg_trig_pkg::ttype_t      ttype;
  dbg_trig_pkg::match_mode_t mode;
  logic                      is_mcontrol6;
  logic                      priv_en_if;      // Privilege enable at IF
  logic                      priv_en_ex;      // Privilege enable at EX
  logic                      if_addr_hit;
  logic                      lsu_access_en;   // Load or store enabled for this access
  logic                      lsu_addr_hit;
  logic [1:0]                be_low;          // Lowest enabled byte index
  logic [1:0]                be_high;         // Highest enabled byte index
  dbg_trig_pkg::xlen_t       lsu_addr_low;
  dbg_trig_pkg::xlen_t       lsu_addr_high;
  dbg_trig_pkg::byte_en_t    byte_hit;        // Enabled lanes equal to tdata2[1:0]

  //////////////////////////////////////////////////////////////////////
  // Field decode
  //////////////////////////////////////////////////////////////////////

  assign ttype        = tdata1_i[`TDATA1_TTYPE_HIGH:`TDATA1_TTYPE_LOW];
  assign mode         = tdata1_i[`MCONTROL6_MATCH_HIGH:`MCONTROL6_MATCH_LOW];
  assign is_mcontrol6 = (ttype == `TTYPE_MCONTROL6);

  assign priv_en_if = (tdata1_i[`MCONTROL6_M] && (priv_lvl_if_i == `PRIV_LVL_M)) ||
                      (tdata1_i[`MCONTROL6_U] && (priv_lvl_if_i == `PRIV_LVL_U));
  assign priv_en_ex = (tdata1_i[`MCONTROL6_M] && (priv_lvl_ex_i == `PRIV_LVL_M)) ||
                      (tdata1_i[`MCONTROL6_U] && (priv_lvl_ex_i == `PRIV_LVL_U));

  //////////////////////////////////////////////////////////////////////
  // Instruction address match
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    case (mode)
      `MATCH_EQ: if_addr_hit = (pc_if_i == tdata2_i);
      `MATCH_GE: if_addr_hit = (pc_if_i >= tdata2_i);
      default:   if_addr_hit = (pc_if_i <  tdata2_i);  // Less than
    endcase
  end

  assign match_if_o = is_mcontrol6 && tdata1_i[`MCONTROL6_EXECUTE] && priv_en_if &&
                      !debug_mode_i && if_addr_hit;

  //////////////////////////////////////////////////////////////////////
  // Load/store address match
  //////////////////////////////////////////////////////////////////////

  // Span of the access within the word, both 0 with no lane enabled
  always_comb begin
    be_low  = 2'd0;
    be_high = 2'd0;
    for (int b = 0; b < 4; b++) begin
      if (lsu_be_ex_i[b]) begin
        be_high = 2'(b);  // Last set lane wins
      end
    end
    for (int b = 3; b >= 0; b--) begin
      if (lsu_be_ex_i[b]) begin
        be_low = 2'(b);   // First set lane wins
      end
    end
  end

  assign lsu_addr_low  = {lsu_addr_ex_i[31:2], be_low};
  assign lsu_addr_high = {lsu_addr_ex_i[31:2], be_high};

  always_comb begin
    for (int b = 0; b < 4; b++) begin
      byte_hit[b] = lsu_be_ex_i[b] && (2'(b) == tdata2_i[1:0]);
    end
  end

  always_comb begin
    case (mode)
      `MATCH_EQ: lsu_addr_hit = (lsu_addr_ex_i[31:2] == tdata2_i[31:2]) && (|byte_hit);
      `MATCH_GE: lsu_addr_hit = (lsu_addr_high >= tdata2_i);  // Any byte at or above
      default:   lsu_addr_hit = (lsu_addr_low  <  tdata2_i);  // Any byte below
    endcase
  end

  assign lsu_access_en = (tdata1_i[`MCONTROL6_LOAD]  && !lsu_we_ex_i) ||
                         (tdata1_i[`MCONTROL6_STORE] &&  lsu_we_ex_i);

  assign match_ex_o = lsu_valid_ex_i && is_mcontrol6 && lsu_access_en && priv_en_ex &&
                      !debug_mode_i && lsu_addr_hit;

endmodule

`default_nettype wire

// ==== hdl/dbg_trig_top.sv ====
// Debug trigger unit

`timescale 1ns/1ps
`default_nettype none

`include "dbg_trig_consts.svh"

module dbg_trig_top #(
  parameter int NUM_TRIGGERS = `DBG_TRIG_NUM
) (
  input  wire                          clk,
  input  wire                          rst_i,

  // CSR writes
  input  wire dbg_trig_pkg::xlen_t     csr_wdata_i,
  input  wire                          tselect_we_i,
  input  wire                          tdata1_we_i,
  input  wire                          tdata2_we_i,

  // CSR reads
  output dbg_trig_pkg::xlen_t          tselect_rdata_o,
  output dbg_trig_pkg::xlen_t          tdata1_rdata_o,
  output dbg_trig_pkg::xlen_t          tdata2_rdata_o,

  // IF stage
  input  wire dbg_trig_pkg::xlen_t     pc_if_i,
  input  wire dbg_trig_pkg::priv_lvl_t priv_lvl_if_i,

  // EX stage
  input  wire                          lsu_valid_ex_i,
  input  wire dbg_trig_pkg::xlen_t     lsu_addr_ex_i,
  input  wire                          lsu_we_ex_i,
  input  wire dbg_trig_pkg::byte_en_t  lsu_be_ex_i,
  input  wire dbg_trig_pkg::priv_lvl_t priv_lvl_ex_i,

  input  wire                          debug_mode_i,

  output logic                         trigger_match_if_o,  // Any trigger hit at IF
  output logic                         trigger_match_ex_o   // Any trigger hit at EX
);

  dbg_trig_pkg::xlen_t     tdata1_all [NUM_TRIGGERS];
  dbg_trig_pkg::xlen_t     tdata2_all [NUM_TRIGGERS];
  logic [NUM_TRIGGERS-1:0] match_if;  // Per trigger IF hits
  logic [NUM_TRIGGERS-1:0] match_ex;  // Per trigger EX hits

  trig_csr_file #(
    .NUM_TRIGGERS (NUM_TRIGGERS)
  ) csr_file_i (
    .clk             (clk),
    .rst_i           (rst_i),
    .csr_wdata_i     (csr_wdata_i),
    .tselect_we_i    (tselect_we_i),
    .tdata1_we_i     (tdata1_we_i),
    .tdata2_we_i     (tdata2_we_i),
    .tselect_rdata_o (tselect_rdata_o),
    .tdata1_rdata_o  (tdata1_rdata_o),
    .tdata2_rdata_o  (tdata2_rdata_o),
    .tdata1_all_o    (tdata1_all),
    .tdata2_all_o    (tdata2_all)
  );

  // One matcher per trigger
  for (genvar idx = 0; idx < NUM_TRIGGERS; idx++) begin : gen_match
    trig_addr_match match_i (
      .tdata1_i       (tdata1_all[idx]),
      .tdata2_i       (tdata2_all[idx]),
      .pc_if_i        (pc_if_i),
      .priv_lvl_if_i  (priv_lvl_if_i),
      .lsu_valid_ex_i (lsu_valid_ex_i),
      .lsu_addr_ex_i  (lsu_addr_ex_i),
      .lsu_we_ex_i    (lsu_we_ex_i),
      .lsu_be_ex_i    (lsu_be_ex_i),
      .priv_lvl_ex_i  (priv_lvl_ex_i),
      .debug_mode_i   (debug_mode_i),
      .match_if_o     (match_if[idx]),
      .match_ex_o     (match_ex[idx])
    );
  end

  assign trigger_match_if_o = |match_if;
  assign trigger_match_ex_o = |match_ex;

endmodule

`default_nettype wire

// ==== testbench/dbg_trig_assert.sv ====
// Trigger unit assertions

`timescale 1ns/1ps
`default_nettype none

`include "dbg_trig_consts.svh"

module dbg_trig_assert #(
  parameter int NUM_TRIGGERS = `DBG_TRIG_NUM
) (
  input wire                      clk,
  input wire                      rst_i,
  input wire                      debug_mode_i,
  input wire dbg_trig_pkg::xlen_t tselect_rdata_i,
  input wire dbg_trig_pkg::xlen_t tdata1_rdata_i,
  input wire                      trigger_match_if_i,
  input wire                      trigger_match_ex_i
);

  int fail_cnt = 0;  // Read by the testbench top

  // No hits while halted
  debug_quiet: assert property (@(posedge clk) disable iff (rst_i)
    debug_mode_i |-> (!trigger_match_if_i && !trigger_match_ex_i))
    else begin
      fail_cnt++;
      $error("Trigger match raised in debug mode");
    end

  sel_in_range: assert property (@(posedge clk) disable iff (rst_i)
    tselect_rdata_i < NUM_TRIGGERS)
    else begin
      fail_cnt++;
      $error("tselect outside the trigger range");
    end

  // First cycle out of reset
  reset_value: assert property (@(posedge clk)
    $fell(rst_i) |-> (tdata1_rdata_i == `TDATA1_RST_VAL))
    else begin
      fail_cnt++;
      $error("tdata1 not at its reset value after reset");
    end

endmodule

bind dbg_trig_top dbg_trig_assert #(
  .NUM_TRIGGERS (NUM_TRIGGERS)
) assert_i (
  .clk                (clk),
  .rst_i              (rst_i),
  .debug_mode_i       (debug_mode_i),
  .tselect_rdata_i    (tselect_rdata_o),
  .tdata1_rdata_i     (tdata1_rdata_o),
  .trigger_match_if_i (trigger_match_if_o),
  .trigger_match_ex_i (trigger_match_ex_o)
);

`default_nettype wire

// ==== testbench/tb_dbg_trig_checker.sv ====
// Trigger unit checker

`timescale 1ns/1ps
`default_nettype none

`include "dbg_trig_consts.svh"

module tb_dbg_trig_checker #(
  parameter int NUM_TRIGGERS = `DBG_TRIG_NUM
) (
  input  wire                          clk,
  input  wire                          rst_i,
  input  wire dbg_trig_pkg::xlen_t     csr_wdata_i,
  input  wire                          tselect_we_i,
  input  wire                          tdata1_we_i,
  input  wire                          tdata2_we_i,
  input  wire dbg_trig_pkg::xlen_t     tselect_rdata_i,
  input  wire dbg_trig_pkg::xlen_t     tdata1_rdata_i,
  input  wire dbg_trig_pkg::xlen_t     tdata2_rdata_i,
  input  wire dbg_trig_pkg::xlen_t     pc_if_i,
  input  wire dbg_trig_pkg::priv_lvl_t priv_lvl_if_i,
  input  wire                          lsu_valid_ex_i,
  input  wire dbg_trig_pkg::xlen_t     lsu_addr_ex_i,
  input  wire                          lsu_we_ex_i,
  input  wire dbg_trig_pkg::byte_en_t  lsu_be_ex_i,
  input  wire dbg_trig_pkg::priv_lvl_t priv_lvl_ex_i,
  input  wire                          debug_mode_i,
  input  wire                          trigger_match_if_i,
  input  wire                          trigger_match_ex_i,
  output int                           err_cnt_o,
  output int                           check_cnt_o
);

  dbg_trig_pkg::xlen_t sel_m;                 // Model of tselect
  dbg_trig_pkg::xlen_t t1_m [NUM_TRIGGERS];   // Model of each tdata1
  dbg_trig_pkg::xlen_t t2_m [NUM_TRIGGERS];
  logic                exp_if;
  logic                exp_ex;

  // tdata1 after a write, WARL by type field
  function automatic dbg_trig_pkg::xlen_t tdata1_written(
    input dbg_trig_pkg::xlen_t old_val,
    input dbg_trig_pkg::xlen_t wdata
  );
    dbg_trig_pkg::match_mode_t code;
    code = wdata[10:7];
    if (code != 4'd0 && code != 4'd2 && code != 4'd3) begin
      code = 4'd0;  // Unsupported compare falls back to equal
    end
    if (wdata[31:28] == 4'd6) begin
      return 32'h6800_1000 | (32'(code) << 7) | (wdata & 32'h0000_0047);
    end else if (wdata[31:28] == 4'd15) begin
      return 32'hF800_0000;
    end
    return old_val;
  endfunction

  function automatic logic priv_ok(input dbg_trig_pkg::xlen_t t1,
                                   input dbg_trig_pkg::priv_lvl_t lvl);
    return (lvl == 2'd3 && t1[6]) || (lvl == 2'd0 && t1[3]);
  endfunction

  function automatic logic if_hit(input dbg_trig_pkg::xlen_t t1, t2);
    logic cmp;
    if (t1[10:7] == 4'd0) begin
      cmp = (pc_if_i == t2);
    end else if (t1[10:7] == 4'd2) begin
      cmp = (pc_if_i >= t2);
    end else begin
      cmp = (pc_if_i < t2);
    end
    return (t1[31:28] == 4'd6) && t1[2] && priv_ok(t1, priv_lvl_if_i) && !debug_mode_i && cmp;
  endfunction

  function automatic logic ex_hit(input dbg_trig_pkg::xlen_t t1, t2);
    logic [1:0] lo;
    logic [1:0] hi;
    logic       found;
    logic       cmp;
    logic       rw_ok;
    lo    = 2'd0;
    hi    = 2'd0;
    found = 1'b0;
    for (int i = 0; i < 4; i++) begin
      if (lsu_be_ex_i[i]) begin
        if (!found) lo = 2'(i);
        hi    = 2'(i);
        found = 1'b1;
      end
    end
    if (t1[10:7] == 4'd0) begin
      cmp = (lsu_addr_ex_i[31:2] == t2[31:2]) && lsu_be_ex_i[t2[1:0]];
    end else if (t1[10:7] == 4'd2) begin
      cmp = ({lsu_addr_ex_i[31:2], hi} >= t2);
    end else begin
      cmp = ({lsu_addr_ex_i[31:2], lo} < t2);
    end
    rw_ok = lsu_we_ex_i ? t1[1] : t1[0];
    return lsu_valid_ex_i && (t1[31:28] == 4'd6) && rw_ok &&
           priv_ok(t1, priv_lvl_ex_i) && !debug_mode_i && cmp;
  endfunction

  task automatic check_value(input string name, input dbg_trig_pkg::xlen_t exp_val,
                             input dbg_trig_pkg::xlen_t act_val);
    if (act_val !== exp_val) begin
      err_cnt_o++;
      $display("** Error: %s expected %h got %h at %0t", name, exp_val, act_val, $time);
    end
  endtask

  initial begin
    err_cnt_o   = 0;
    check_cnt_o = 0;
  end

  // Compare mid cycle, then apply this cycle's writes to the model
  always @(negedge clk) begin
    if (rst_i) begin
      sel_m = '0;
      for (int i = 0; i < NUM_TRIGGERS; i++) begin
        t1_m[i] = 32'hF800_0000;
        t2_m[i] = '0;
      end
    end else begin
      exp_if = 1'b0;
      exp_ex = 1'b0;
      for (int i = 0; i < NUM_TRIGGERS; i++) begin
        exp_if |= if_hit(t1_m[i], t2_m[i]);
        exp_ex |= ex_hit(t1_m[i], t2_m[i]);
      end
      check_value("tselect_rdata_o", sel_m, tselect_rdata_i);
      check_value("tdata1_rdata_o", t1_m[sel_m], tdata1_rdata_i);
      check_value("tdata2_rdata_o", t2_m[sel_m], tdata2_rdata_i);
      check_value("trigger_match_if_o", 32'(exp_if), 32'(trigger_match_if_i));
      check_value("trigger_match_ex_o", 32'(exp_ex), 32'(trigger_match_ex_i));
      check_cnt_o++;
      if (tdata1_we_i) t1_m[sel_m] = tdata1_written(t1_m[sel_m], csr_wdata_i);
      if (tdata2_we_i) t2_m[sel_m] = csr_wdata_i;
      if (tselect_we_i && csr_wdata_i < NUM_TRIGGERS) begin
        sel_m = csr_wdata_i;  // Data and select writes use the old select
      end
    end
  end

endmodule

`default_nettype wire

// ==== testbench/tb_dbg_trig.sv ====
// Debug trigger unit testbench

`timescale 1ns/1ps
`default_nettype none

`include "dbg_trig_consts.svh"

module tb_dbg_trig;

  localparam int NUM_CYCLES = 4000;  // Random stimulus cycles after reset
  localparam int CLK_PERIOD = 10;
  localparam int RST_CYCLES = 5;

  logic                    clk;
  logic                    rst_i;
  dbg_trig_pkg::xlen_t     csr_wdata_i;
  logic                    tselect_we_i;
  logic                    tdata1_we_i;
  logic                    tdata2_we_i;
  dbg_trig_pkg::xlen_t     tselect_rdata_o;
  dbg_trig_pkg::xlen_t     tdata1_rdata_o;
  dbg_trig_pkg::xlen_t     tdata2_rdata_o;
  dbg_trig_pkg::xlen_t     pc_if_i;
  dbg_trig_pkg::priv_lvl_t priv_lvl_if_i;
  logic                    lsu_valid_ex_i;
  dbg_trig_pkg::xlen_t     lsu_addr_ex_i;
  logic                    lsu_we_ex_i;
  dbg_trig_pkg::byte_en_t  lsu_be_ex_i;
  dbg_trig_pkg::priv_lvl_t priv_lvl_ex_i;
  logic                    debug_mode_i;
  logic                    trigger_match_if_o;
  logic                    trigger_match_ex_o;

  int seed;          // $random state
  int err_cnt;       // Mismatches seen by the checker
  int check_cnt;
  int timeout_errs;

  dbg_trig_top #(
    .NUM_TRIGGERS (`DBG_TRIG_NUM)
  ) dut_i (
    .clk                (clk),
    .rst_i              (rst_i),
    .csr_wdata_i        (csr_wdata_i),
    .tselect_we_i       (tselect_we_i),
    .tdata1_we_i        (tdata1_we_i),
    .tdata2_we_i        (tdata2_we_i),
    .tselect_rdata_o    (tselect_rdata_o),
    .tdata1_rdata_o     (tdata1_rdata_o),
    .tdata2_rdata_o     (tdata2_rdata_o),
    .pc_if_i            (pc_if_i),
    .priv_lvl_if_i      (priv_lvl_if_i),
    .lsu_valid_ex_i     (lsu_valid_ex_i),
    .lsu_addr_ex_i      (lsu_addr_ex_i),
    .lsu_we_ex_i        (lsu_we_ex_i),
    .lsu_be_ex_i        (lsu_be_ex_i),
    .priv_lvl_ex_i      (priv_lvl_ex_i),
    .debug_mode_i       (debug_mode_i),
    .trigger_match_if_o (trigger_match_if_o),
    .trigger_match_ex_o (trigger_match_ex_o)
  );

  tb_dbg_trig_checker #(
    .NUM_TRIGGERS (`DBG_TRIG_NUM)
  ) checker_i (
    .clk                (clk),
    .rst_i              (rst_i),
    .csr_wdata_i        (csr_wdata_i),
    .tselect_we_i       (tselect_we_i),
    .tdata1_we_i        (tdata1_we_i),
    .tdata2_we_i        (tdata2_we_i),
    .tselect_rdata_i    (tselect_rdata_o),
    .tdata1_rdata_i     (tdata1_rdata_o),
    .tdata2_rdata_i     (tdata2_rdata_o),
    .pc_if_i            (pc_if_i),
    .priv_lvl_if_i      (priv_lvl_if_i),
    .lsu_valid_ex_i     (lsu_valid_ex_i),
    .lsu_addr_ex_i      (lsu_addr_ex_i),
    .lsu_we_ex_i        (lsu_we_ex_i),
    .lsu_be_ex_i        (lsu_be_ex_i),
    .priv_lvl_ex_i      (priv_lvl_ex_i),
    .debug_mode_i       (debug_mode_i),
    .trigger_match_if_i (trigger_match_if_o),
    .trigger_match_ex_i (trigger_match_ex_o),
    .err_cnt_o          (err_cnt),
    .check_cnt_o        (check_cnt)
  );

  initial clk = 1'b0;
  always #(CLK_PERIOD / 2) clk = ~clk;

  ////////////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////////////

  // One cycle of random CSR traffic and pipeline activity
  task automatic drive_random_cycle();
    logic [31:0]         r_kind;
    logic [31:0]         r_data;
    logic [31:0]         r_misc;
    dbg_trig_pkg::xlen_t wdata;
    dbg_trig_pkg::xlen_t near;  // Small signed offset from -4 to 3
    r_kind = $random(seed);
    r_data = $random(seed);
    r_misc = $random(seed);
    near   = {{29{r_data[2]}}, r_data[2:0]};
    wdata  = r_data;
    case (r_kind[4:3])  // Pick the flavor of write data
      2'd0:    wdata = (r_kind[2:0] == 3'd0) ? {r_data[31:2], 2'b00} : {4'h6, r_data[27:0]};
      2'd1:    wdata = (r_kind[2:0] == 3'd0) ? {30'd0, r_data[1:0]} : {4'hF, r_data[27:0]};
      2'd2:    wdata = (r_kind[2:0] == 3'd0) ? {30'd0, r_data[1:0]} : {4'h5, r_data[27:0]};
      default: wdata = (r_kind[2:0] == 3'd0) ? {30'd0, r_data[1:0]} : r_data;
    endcase
    if (r_kind[2:0] >= 3'd2 && r_kind[3]) begin
      wdata = r_kind[4] ? pc_if_i + near : lsu_addr_ex_i + near;  // Aim tdata2 at traffic
    end
    csr_wdata_i    <= wdata;
    tselect_we_i   <= (r_kind[2:0] == 3'd0);
    tdata1_we_i    <= (r_kind[2:0] == 3'd1);
    tdata2_we_i    <= (r_kind[2:0] == 3'd2) || (r_kind[2:0] == 3'd3);
    pc_if_i        <= {24'h000010, r_misc[7:2], 2'b00};  // Aligned fetch in a small window
    lsu_addr_ex_i  <= {24'h000010, r_misc[15:8]};
    lsu_valid_ex_i <= r_misc[16] | r_misc[17];
    lsu_we_ex_i    <= r_misc[18];
    lsu_be_ex_i    <= r_misc[22:19];                      // Zero enables included
    priv_lvl_if_i  <= r_misc[23] ? {2{r_misc[24]}} : r_misc[25:24];
    priv_lvl_ex_i  <= r_misc[26] ? {2{r_misc[27]}} : r_misc[28:27];
    debug_mode_i   <= (r_kind[15:8] < 8'd26);             // About 10 percent
  endtask

  // Closing line and verdict
  task automatic finish_run();
    int assert_errs;
    int total;
    assert_errs = dut_i.assert_i.fail_cnt;
    total = err_cnt + assert_errs + timeout_errs;
    $display("Checks %0d, mismatches %0d, assertion failures %0d, timeouts %0d",
             check_cnt, err_cnt, assert_errs, timeout_errs);
    if (total == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  endtask

  initial begin
    seed           = 79;
    timeout_errs   = 0;
    rst_i          = 1'b1;
    csr_wdata_i    = '0;
    tselect_we_i   = 1'b0;
    tdata1_we_i    = 1'b0;
    tdata2_we_i    = 1'b0;
    pc_if_i        = '0;
    priv_lvl_if_i  = '0;
    lsu_valid_ex_i = 1'b0;
    lsu_addr_ex_i  = '0;
    lsu_we_ex_i    = 1'b0;
    lsu_be_ex_i    = '0;
    priv_lvl_ex_i  = '0;
    debug_mode_i   = 1'b0;
    repeat (RST_CYCLES) @(posedge clk);
    rst_i <= 1'b0;
    repeat (NUM_CYCLES) begin
      drive_random_cycle();
      @(posedge clk);
    end
    @(posedge clk);  // Last cycle compared at the negedge before
    finish_run();
  end

  // Watchdog at twice the stimulus length
  initial begin
    #(2 * NUM_CYCLES * CLK_PERIOD);
    $display("Watchdog expired, the stimulus did not complete in time");
    timeout_errs++;
    finish_run();
  end

endmodule

`default_nettype wire

// ==== files.f ====
+incdir+hdl
hdl/dbg_trig_pkg.sv
hdl/trig_csr_file.sv
hdl/trig_addr_match.sv
hdl/dbg_trig_top.sv
testbench/dbg_trig_assert.sv
testbench/tb_dbg_trig_checker.sv
testbench/tb_dbg_trig.sv

// ==== Bender.yml ====
package:
  name: dbg_trig

export_include_dirs:
  - hdl

sources:
  - files:
      - hdl/dbg_trig_pkg.sv
      - hdl/trig_csr_file.sv
      - hdl/trig_addr_match.sv
      - hdl/dbg_trig_top.sv
  - target: simulation
    files:
      - testbench/dbg_trig_assert.sv
      - testbench/tb_dbg_trig_checker.sv
      - testbench/tb_dbg_trig.sv
